/* verilog/memreq_pkg.sv */
package memreq_pkg;

  localparam int DATA_WIDTH = 32;  // Memory word
  localparam int ADDR_WIDTH = 28;
  localparam int ID_WIDTH = 4;

  localparam int RD_FIFO_DEPTH = 16;  // Words
  localparam int WR_FIFO_DEPTH = 4;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [ID_WIDTH-1:0] id_t;
  typedef logic [7:0] len_t;  // Beats minus one
  typedef logic [7:0] byte_t;
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

  // Request codes, bit 7 set for reads
  localparam byte_t CMD_STORE = 8'h01;
  localparam byte_t CMD_FETCH = 8'h80;

  // Reply codes
  localparam byte_t CMD_WDONE = 8'h02;
  localparam byte_t CMD_WFAIL = 8'h03;
  localparam byte_t CMD_RDATA = 8'h81;
  localparam byte_t CMD_RFAIL = 8'h82;

  typedef enum logic [2:0] {
    IDLE,
    HEADER,
    WPAYLOAD,
    WAIT,
    REPLY
  } req_state_e;

endpackage

/* verilog/cmd_parser.sv */
`timescale 1ns/1ps
module cmd_parser (
  input  logic                bus_clock,
  input  logic                bus_reset,

  input  logic                s_tvalid_i,
  output logic                s_tready_o,
  input  logic                s_tlast_i,
  input  memreq_pkg::byte_t   s_tdata_i,

  input  logic                wfifo_full_i,
  input  logic                reply_done_i,

  output logic                wr_start_o,
  output logic                rd_start_o,
  output memreq_pkg::addr_t   req_addr_o,
  output memreq_pkg::len_t    req_len_o,
  output memreq_pkg::id_t     req_id_o,

  output logic                pay_valid_o,
  output memreq_pkg::byte_t   pay_data_o,
  output logic                pay_last_o
);

  memreq_pkg::req_state_e state_q;
  memreq_pkg::byte_t cmd_q;
  logic [4:0] ptr_q;  // One-hot over header bytes 2 to 6
  logic s_fire;
  logic hdr_end;
  logic is_read;
  logic is_write;

  assign s_tready_o = (state_q == memreq_pkg::IDLE) || (state_q == memreq_pkg::HEADER) ||
                      (state_q == memreq_pkg::WPAYLOAD && !wfifo_full_i);
  assign s_fire = s_tvalid_i && s_tready_o;
  assign hdr_end = s_fire && state_q == memreq_pkg::HEADER && ptr_q[4];

  assign is_read = (cmd_q[7] == memreq_pkg::CMD_FETCH[7]);
  assign is_write = (cmd_q[7] == memreq_pkg::CMD_STORE[7]);

  // Payload bytes go straight to the packer
  assign pay_valid_o = s_fire && state_q == memreq_pkg::WPAYLOAD;
  assign pay_data_o = s_tdata_i;
  assign pay_last_o = s_tlast_i;

  always_ff @(posedge bus_clock) begin
    if (s_fire && state_q == memreq_pkg::IDLE) begin
      cmd_q <= s_tdata_i;
    end
    if (s_fire && state_q == memreq_pkg::HEADER) begin
      if (ptr_q[0]) req_len_o <= s_tdata_i;
      if (ptr_q[1]) req_addr_o[7:0] <= s_tdata_i;
      if (ptr_q[2]) req_addr_o[15:8] <= s_tdata_i;
      if (ptr_q[3]) req_addr_o[23:16] <= s_tdata_i;
      if (ptr_q[4]) begin
        {req_id_o, req_addr_o[27:24]} <= s_tdata_i;  // Id in the high nibble
      end
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= memreq_pkg::IDLE;
      ptr_q <= '0;
      wr_start_o <= 1'b0;
      rd_start_o <= 1'b0;
    end else begin
      wr_start_o <= hdr_end && is_write;
      rd_start_o <= hdr_end && is_read;
      case (state_q)
        memreq_pkg::IDLE: begin
          if (s_fire) begin
            state_q <= memreq_pkg::HEADER;
            ptr_q <= 5'b00001;
          end
        end
        memreq_pkg::HEADER: begin
          if (s_fire) begin
            ptr_q <= {ptr_q[3:0], 1'b0};
            if (ptr_q[4]) begin
              state_q <= is_read ? memreq_pkg::WAIT : memreq_pkg::WPAYLOAD;
            end
          end
        end
        memreq_pkg::WPAYLOAD: begin
          if (s_fire && s_tlast_i) state_q <= memreq_pkg::WAIT;
        end
        memreq_pkg::WAIT: begin
          // Hold off the next command until the reply is out
          if (reply_done_i) state_q <= memreq_pkg::REPLY;
        end
        default: state_q <= memreq_pkg::IDLE;  // One turnaround cycle
      endcase
    end
  end

endmodule

/* verilog/word_packer.sv */
`timescale 1ns/1ps
module word_packer (
  input  logic                bus_clock,
  input  logic                bus_reset,

  input  logic                pay_valid_i,
  input  memreq_pkg::byte_t   pay_data_i,
  input  logic                pay_last_i,

  output logic                word_valid_o,
  output memreq_pkg::data_t   word_data_o,
  output logic                word_last_o
);

  logic [1:0] lane_q;

  // Bytes enter at the top, so the first lands in bits 7:0
  always_ff @(posedge bus_clock) begin
    if (pay_valid_i) begin
      word_data_o <= {pay_data_i, word_data_o[memreq_pkg::DATA_WIDTH-1:8]};
      word_last_o <= pay_last_i;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      lane_q <= 2'd0;
      word_valid_o <= 1'b0;
    end else begin
      word_valid_o <= pay_valid_i && lane_q == 2'd3;
      if (pay_valid_i) begin
        lane_q <= lane_q + 2'd1;  // Back to 0 after every fourth byte
      end
    end
  end

endmodule

/* verilog/word_fifo.sv */
`timescale 1ns/1ps
module word_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                bus_clock,
  input  logic                bus_reset,

  input  logic                push_i,
  input  memreq_pkg::data_t   push_data_i,
  input  logic                push_last_i,

  input  logic                pop_i,
  output memreq_pkg::data_t   pop_data_o,
  output logic                pop_last_o,

  output logic                empty_o,
  output logic                full_o
);

  localparam int AW = $clog2(DEPTH);

  memreq_pkg::data_t data_q [DEPTH];
  logic last_q [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0] count_q;
  logic push_ok;
  logic pop_ok;

  assign empty_o = (count_q == '0);
  assign full_o = (count_q == (AW + 1)'(DEPTH));
  assign push_ok = push_i && !full_o;
  assign pop_ok = pop_i && !empty_o;

  // Front entry visible whenever not empty
  assign pop_data_o = data_q[rd_ptr_q];
  assign pop_last_o = last_q[rd_ptr_q];

  always_ff @(posedge bus_clock) begin
    if (push_ok) begin
      data_q[wr_ptr_q] <= push_data_i;
      last_q[wr_ptr_q] <= push_last_i;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps, depth is a power of two
      if (pop_ok) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* verilog/write_port.sv */
`timescale 1ns/1ps
module write_port (
  input  logic                bus_clock,
  input  logic                bus_reset,

  input  logic                wr_start_i,
  input  memreq_pkg::addr_t   req_addr_i,
  input  memreq_pkg::len_t    req_len_i,
  input  memreq_pkg::id_t     req_id_i,

  output logic                awvalid_o,
  input  logic                awready_i,
  output memreq_pkg::addr_t   awaddr_o,
  output memreq_pkg::len_t    awlen_o,
  output memreq_pkg::id_t     awid_o,

  output logic                wvalid_o,
  input  logic                wready_i,
  output logic                wlast_o,
  output memreq_pkg::data_t   wdata_o,

  input  logic                bvalid_i,
  output logic                bready_o,
  input  memreq_pkg::resp_t   bresp_i,
  input  memreq_pkg::id_t     bid_i,

  input  logic                fifo_empty_i,
  input  memreq_pkg::data_t   fifo_data_i,
  input  logic                fifo_last_i,
  output logic                fifo_pop_o,

  output logic                wr_done_o,
  output logic                wr_ok_o,
  output memreq_pkg::id_t     wr_id_o
);

  typedef enum logic [1:0] {IDLE, ADDR, DATA, RESP} wr_state_e;

  wr_state_e state_q;

  assign awvalid_o = (state_q == ADDR);
  assign wvalid_o = (state_q == DATA) && !fifo_empty_i;
  assign wdata_o = fifo_data_i;
  assign wlast_o = fifo_last_i;
  assign fifo_pop_o = wvalid_o && wready_i;  // One pop per accepted beat
  assign bready_o = (state_q == RESP);

  always_ff @(posedge bus_clock) begin
    if (state_q == IDLE && wr_start_i) begin
      awaddr_o <= req_addr_i;
      awlen_o <= req_len_i;
      awid_o <= req_id_i;
    end
    wr_ok_o <= (bresp_i == memreq_pkg::RESP_OKAY);
    wr_id_o <= bid_i;
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= IDLE;
      wr_done_o <= 1'b0;
    end else begin
      wr_done_o <= bvalid_i && bready_o;
      case (state_q)
        IDLE: if (wr_start_i) state_q <= ADDR;
        ADDR: if (awready_i) state_q <= DATA;
        DATA: if (fifo_pop_o && fifo_last_i) state_q <= RESP;
        RESP: if (bvalid_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

/* verilog/read_port.sv */
`timescale 1ns/1ps
module read_port (
  input  logic                bus_clock,
  input  logic                bus_reset,

  input  logic                rd_start_i,
  input  memreq_pkg::addr_t   req_addr_i,
  input  memreq_pkg::len_t    req_len_i,
  input  memreq_pkg::id_t     req_id_i,

  output logic                arvalid_o,
  input  logic                arready_i,
  output memreq_pkg::addr_t   araddr_o,
  output memreq_pkg::len_t    arlen_o,
  output memreq_pkg::id_t     arid_o,

  input  logic                rvalid_i,
  output logic                rready_o,
  input  logic                rlast_i,
  input  memreq_pkg::resp_t   rresp_i,
  input  memreq_pkg::id_t     rid_i,
  input  memreq_pkg::data_t   rdata_i,

  input  logic                fifo_full_i,
  output logic                fifo_push_o,
  output memreq_pkg::data_t   fifo_data_o,
  output logic                fifo_last_o,

  output logic                rd_hdr_o,
  output logic                rd_ok_o,
  output memreq_pkg::id_t     rd_id_o
);

  typedef enum logic [1:0] {IDLE, ADDR, DATA} rd_state_e;

  rd_state_e state_q;
  logic first_q;  // Next beat is the first of the burst

  assign arvalid_o = (state_q == ADDR);
  assign rready_o = (state_q == DATA) && !fifo_full_i;
  assign fifo_push_o = rvalid_i && rready_o;
  assign fifo_data_o = rdata_i;
  assign fifo_last_o = rlast_i;

  always_ff @(posedge bus_clock) begin
    if (state_q == IDLE && rd_start_i) begin
      araddr_o <= req_addr_i;
      arlen_o <= req_len_i;
      arid_o <= req_id_i;
    end
    rd_ok_o <= (rresp_i == memreq_pkg::RESP_OKAY);
    rd_id_o <= rid_i;
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= IDLE;
      first_q <= 1'b0;
      rd_hdr_o <= 1'b0;
    end else begin
      rd_hdr_o <= fifo_push_o && first_q;
      if (fifo_push_o) first_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (rd_start_i) begin
            state_q <= ADDR;
            first_q <= 1'b1;
          end
        end
        ADDR: if (arready_i) state_q <= DATA;
        DATA: if (fifo_push_o && rlast_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

/* verilog/resp_sender.sv */
`timescale 1ns/1ps
module resp_sender (
  input  logic                bus_clock,
  input  logic                bus_reset,

  input  logic                wr_done_i,
  input  logic                wr_ok_i,
  input  memreq_pkg::id_t     wr_id_i,

  input  logic                rd_hdr_i,
  input  logic                rd_ok_i,
  input  memreq_pkg::id_t     rd_id_i,

  input  logic                rfifo_empty_i,
  input  memreq_pkg::data_t   rfifo_data_i,
  input  logic                rfifo_last_i,
  output logic                rfifo_pop_o,

  output logic                m_tvalid_o,
  input  logic                m_tready_i,
  output logic                m_tlast_o,
  output memreq_pkg::byte_t   m_tdata_o,

  output logic                reply_done_o
);

  typedef enum logic [1:0] {IDLE, CODE, ID, DATA} tx_state_e;

  tx_state_e state_q;
  memreq_pkg::byte_t code_q;
  memreq_pkg::id_t id_q;
  logic is_rd_q;
  logic [1:0] lane_q;  // Byte lane of the front word
  logic m_fire;

  assign m_tvalid_o = (state_q == CODE) || (state_q == ID) ||
                      (state_q == DATA && !rfifo_empty_i);
  assign m_fire = m_tvalid_o && m_tready_i;

  always_comb begin
    case (state_q)
      CODE: m_tdata_o = code_q;
      ID: m_tdata_o = {{(8 - memreq_pkg::ID_WIDTH){1'b0}}, id_q};
      default: m_tdata_o = rfifo_data_i[{lane_q, 3'b000} +: 8];  // LSB first
    endcase
  end

  assign m_tlast_o = (state_q == ID && !is_rd_q) ||
                     (state_q == DATA && lane_q == 2'd3 && rfifo_last_i);
  assign rfifo_pop_o = m_fire && state_q == DATA && lane_q == 2'd3;
  assign reply_done_o = m_fire && m_tlast_o;

  always_ff @(posedge bus_clock) begin
    if (state_q == IDLE) begin
      if (wr_done_i) begin
        code_q <= wr_ok_i ? memreq_pkg::CMD_WDONE : memreq_pkg::CMD_WFAIL;
        id_q <= wr_id_i;
      end else begin
        code_q <= rd_ok_i ? memreq_pkg::CMD_RDATA : memreq_pkg::CMD_RFAIL;
        id_q <= rd_id_i;
      end
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= IDLE;
      is_rd_q <= 1'b0;
      lane_q <= 2'd0;
    end else begin
      case (state_q)
        IDLE: begin
          if (wr_done_i || rd_hdr_i) begin
            state_q <= CODE;
            is_rd_q <= !wr_done_i;
          end
        end
        CODE: if (m_fire) state_q <= ID;
        ID: if (m_fire) state_q <= is_rd_q ? DATA : IDLE;
        DATA: begin
          if (m_fire) begin
            lane_q <= lane_q + 2'd1;  // Wraps back to 0 on each pop
            if (m_tlast_o) state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

/* verilog/memreq_top.sv */
`timescale 1ns/1ps
module memreq_top (
  input  logic                bus_clock,
  input  logic                bus_reset,

  input  logic                s_tvalid_i,
  output logic                s_tready_o,
  input  logic                s_tlast_i,
  input  memreq_pkg::byte_t   s_tdata_i,

  output logic                m_tvalid_o,
  input  logic                m_tready_i,
  output logic                m_tlast_o,
  output memreq_pkg::byte_t   m_tdata_o,

  output logic                awvalid_o,
  input  logic                awready_i,
  output memreq_pkg::addr_t   awaddr_o,
  output memreq_pkg::len_t    awlen_o,
  output memreq_pkg::id_t     awid_o,

  output logic                wvalid_o,
  input  logic                wready_i,
  output logic                wlast_o,
  output memreq_pkg::data_t   wdata_o,

  input  logic                bvalid_i,
  output logic                bready_o,
  input  memreq_pkg::resp_t   bresp_i,
  input  memreq_pkg::id_t     bid_i,

  output logic                arvalid_o,
  input  logic                arready_i,
  output memreq_pkg::addr_t   araddr_o,
  output memreq_pkg::len_t    arlen_o,
  output memreq_pkg::id_t     arid_o,

  input  logic                rvalid_i,
  output logic                rready_o,
  input  logic                rlast_i,
  input  memreq_pkg::resp_t   rresp_i,
  input  memreq_pkg::id_t     rid_i,
  input  memreq_pkg::data_t   rdata_i
);

  logic wr_start, rd_start, reply_done;
  memreq_pkg::addr_t req_addr;
  memreq_pkg::len_t req_len;
  memreq_pkg::id_t req_id;

  // Write path
  logic pay_valid, pay_last, word_valid, word_last;
  memreq_pkg::byte_t pay_data;
  memreq_pkg::data_t word_data, wfifo_data;
  logic wfifo_full, wfifo_empty, wfifo_last, wfifo_pop;
  logic wr_done, wr_ok;
  memreq_pkg::id_t wr_id;

  // Read path
  logic rfifo_push, rfifo_wlast, rfifo_full, rfifo_empty, rfifo_last, rfifo_pop;
  memreq_pkg::data_t rfifo_wdata, rfifo_data;
  logic rd_hdr, rd_ok;
  memreq_pkg::id_t rd_id;

  cmd_parser u_cmd_parser (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .s_tvalid_i(s_tvalid_i), .s_tready_o(s_tready_o),
    .s_tlast_i(s_tlast_i), .s_tdata_i(s_tdata_i),
    .wfifo_full_i(wfifo_full), .reply_done_i(reply_done),
    .wr_start_o(wr_start), .rd_start_o(rd_start),
    .req_addr_o(req_addr), .req_len_o(req_len), .req_id_o(req_id),
    .pay_valid_o(pay_valid), .pay_data_o(pay_data), .pay_last_o(pay_last)
  );

  word_packer u_word_packer (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .pay_valid_i(pay_valid), .pay_data_i(pay_data), .pay_last_i(pay_last),
    .word_valid_o(word_valid), .word_data_o(word_data), .word_last_o(word_last)
  );

  word_fifo #(.DEPTH(memreq_pkg::WR_FIFO_DEPTH)) u_wr_fifo (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .push_i(word_valid), .push_data_i(word_data), .push_last_i(word_last),
    .pop_i(wfifo_pop), .pop_data_o(wfifo_data), .pop_last_o(wfifo_last),
    .empty_o(wfifo_empty), .full_o(wfifo_full)
  );

  write_port u_write_port (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .wr_start_i(wr_start), .req_addr_i(req_addr), .req_len_i(req_len), .req_id_i(req_id),
    .awvalid_o(awvalid_o), .awready_i(awready_i),
    .awaddr_o(awaddr_o), .awlen_o(awlen_o), .awid_o(awid_o),
    .wvalid_o(wvalid_o), .wready_i(wready_i), .wlast_o(wlast_o), .wdata_o(wdata_o),
    .bvalid_i(bvalid_i), .bready_o(bready_o), .bresp_i(bresp_i), .bid_i(bid_i),
    .fifo_empty_i(wfifo_empty), .fifo_data_i(wfifo_data),
    .fifo_last_i(wfifo_last), .fifo_pop_o(wfifo_pop),
    .wr_done_o(wr_done), .wr_ok_o(wr_ok), .wr_id_o(wr_id)
  );

  read_port u_read_port (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .rd_start_i(rd_start), .req_addr_i(req_addr), .req_len_i(req_len), .req_id_i(req_id),
    .arvalid_o(arvalid_o), .arready_i(arready_i),
    .araddr_o(araddr_o), .arlen_o(arlen_o), .arid_o(arid_o),
    .rvalid_i(rvalid_i), .rready_o(rready_o), .rlast_i(rlast_i),
    .rresp_i(rresp_i), .rid_i(rid_i), .rdata_i(rdata_i),
    .fifo_full_i(rfifo_full), .fifo_push_o(rfifo_push),
    .fifo_data_o(rfifo_wdata), .fifo_last_o(rfifo_wlast),
    .rd_hdr_o(rd_hdr), .rd_ok_o(rd_ok), .rd_id_o(rd_id)
  );

  word_fifo #(.DEPTH(memreq_pkg::RD_FIFO_DEPTH)) u_rd_fifo (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .push_i(rfifo_push), .push_data_i(rfifo_wdata), .push_last_i(rfifo_wlast),
    .pop_i(rfifo_pop), .pop_data_o(rfifo_data), .pop_last_o(rfifo_last),
    .empty_o(rfifo_empty), .full_o(rfifo_full)
  );

  resp_sender u_resp_sender (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .wr_done_i(wr_done), .wr_ok_i(wr_ok), .wr_id_i(wr_id),
    .rd_hdr_i(rd_hdr), .rd_ok_i(rd_ok), .rd_id_i(rd_id),
    .rfifo_empty_i(rfifo_empty), .rfifo_data_i(rfifo_data),
    .rfifo_last_i(rfifo_last), .rfifo_pop_o(rfifo_pop),
    .m_tvalid_o(m_tvalid_o), .m_tready_i(m_tready_i),
    .m_tlast_o(m_tlast_o), .m_tdata_o(m_tdata_o),
    .reply_done_o(reply_done)
  );

endmodule

/* bench/memreq_props.sv */
`timescale 1ns/1ps
module memreq_props (
  input logic                bus_clock,
  input logic                bus_reset,
  input logic                awvalid_o,
  input logic                awready_i,
  input memreq_pkg::addr_t   awaddr_o,
  input memreq_pkg::len_t    awlen_o,
  input memreq_pkg::id_t     awid_o,
  input logic                wvalid_o,
  input logic                wready_i,
  input logic                wlast_o,
  input memreq_pkg::data_t   wdata_o,
  input logic                arvalid_o,
  input logic                arready_i,
  input memreq_pkg::addr_t   araddr_o,
  input memreq_pkg::len_t    arlen_o,
  input memreq_pkg::id_t     arid_o,
  input logic                m_tvalid_o,
  input logic                m_tready_i,
  input logic                m_tlast_o,
  input memreq_pkg::byte_t   m_tdata_o,
  input logic                bready_o,
  input logic                rready_o
);

  // Valid held and payload frozen until the handshake
  assert property (@(posedge bus_clock) disable iff (bus_reset)
    awvalid_o && !awready_i |=> awvalid_o && $stable({awaddr_o, awlen_o, awid_o}))
    else $error("Write address dropped or changed before awready_i");

  assert property (@(posedge bus_clock) disable iff (bus_reset)
    wvalid_o && !wready_i |=> wvalid_o && $stable({wdata_o, wlast_o}))
    else $error("Write data dropped or changed before wready_i");

  assert property (@(posedge bus_clock) disable iff (bus_reset)
    arvalid_o && !arready_i |=> arvalid_o && $stable({araddr_o, arlen_o, arid_o}))
    else $error("Read address dropped or changed before arready_i");

  assert property (@(posedge bus_clock) disable iff (bus_reset)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable({m_tdata_o, m_tlast_o}))
    else $error("Reply byte dropped or changed before m_tready_i");

  // Nothing offered straight out of reset
  assert property (@(posedge bus_clock)
    bus_reset |=> !(awvalid_o || wvalid_o || arvalid_o || m_tvalid_o || bready_o || rready_o))
    else $error("Valid or ready output high during reset");

endmodule

/* bench/tb_memreq.sv */
`timescale 1ns/1ps
module tb_memreq;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_REQ = 10;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 400 * NUM_REQ;
  localparam logic [31:0] SEED = 32'heff5_d38e;

  // Command, length, address, id, payload seed
  localparam logic [55:0] REQ_TABLE [NUM_REQ] = '{
    {8'h01, 8'd0, 28'h3ab_cd10, 4'h1, 8'h11},
    {8'h80, 8'd0, 28'h3ab_cd10, 4'h2, 8'h00},
    {8'h01, 8'd7, 28'h000_0020, 4'h3, 8'h5a},
    {8'h80, 8'd7, 28'h000_0020, 4'h0, 8'h00},
    {8'h01, 8'd3, 28'h800_0040, 4'h5, 8'h77},  // Bit 27 set, error response
    {8'h80, 8'd1, 28'h800_0040, 4'h6, 8'h00},
    {8'h01, 8'd4, 28'h123_4560, 4'hf, 8'h9c},
    {8'h80, 8'd5, 28'h123_455e, 4'h7, 8'h00},  // Straddles unwritten words
    {8'h01, 8'd2, 28'h000_0023, 4'h9, 8'he1},
    {8'h80, 8'd7, 28'h000_0020, 4'ha, 8'h00}
  };

  logic bus_clock = 1'b0;
  logic bus_reset;
  logic s_tvalid_i, s_tready_o, s_tlast_i;
  memreq_pkg::byte_t s_tdata_i;
  logic m_tvalid_o, m_tready_i, m_tlast_o;
  memreq_pkg::byte_t m_tdata_o;
  logic awvalid_o, wvalid_o, wlast_o, bready_o, arvalid_o, rready_o;
  memreq_pkg::addr_t awaddr_o, araddr_o;
  memreq_pkg::len_t awlen_o, arlen_o;
  memreq_pkg::id_t awid_o, arid_o;
  memreq_pkg::data_t wdata_o;

  // Memory side inputs, owned by the memory model
  logic awready_i = 1'b0;
  logic wready_i = 1'b0;
  logic arready_i = 1'b0;
  logic bvalid_i = 1'b0;
  logic rvalid_i = 1'b0;
  logic rlast_i = 1'b0;
  memreq_pkg::resp_t bresp_i = '0;
  memreq_pkg::resp_t rresp_i = '0;
  memreq_pkg::id_t bid_i = '0;
  memreq_pkg::id_t rid_i = '0;
  memreq_pkg::data_t rdata_i = '0;

  memreq_pkg::data_t mem [256];
  memreq_pkg::data_t exp_mem [256];
  memreq_pkg::data_t wr_log [256];  // Beats of the current write burst
  memreq_pkg::addr_t aw_addr, ar_addr;
  memreq_pkg::len_t aw_len, ar_len;
  memreq_pkg::id_t aw_id, ar_id;
  int wr_count = 0;
  int wlast_at = -1;
  int aw_total = 0;
  int ar_total = 0;
  int r_beat = 0;
  int cycle_count = 0;
  logic r_active = 1'b0;
  logic b_fire = 1'b0;
  logic r_fire = 1'b0;
  logic [31:0] mem_rng = SEED;
  logic [31:0] tb_rng = SEED;

  memreq_top u_memreq_top (.*);

  bind memreq_top memreq_props u_memreq_props (
    .bus_clock, .bus_reset,
    .awvalid_o, .awready_i, .awaddr_o, .awlen_o, .awid_o,
    .wvalid_o, .wready_i, .wlast_o, .wdata_o,
    .arvalid_o, .arready_i, .araddr_o, .arlen_o, .arid_o,
    .m_tvalid_o, .m_tready_i, .m_tlast_o, .m_tdata_o,
    .bready_o, .rready_o
  );

  always #10 bus_clock = ~bus_clock;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic memreq_pkg::data_t fill_word(input int i);
    return {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3 - i[7:0]};
  endfunction

  function automatic memreq_pkg::byte_t payload_byte(input memreq_pkg::byte_t seed, input int k);
    return (seed + k[7:0] * 8'd37) ^ {k[3:0], 4'h0};
  endfunction

  // First payload byte of the beat lands in bits 7:0
  function automatic memreq_pkg::data_t pack_word(input memreq_pkg::byte_t seed, input int beat);
    memreq_pkg::data_t w;
    for (int j = 0; j < 4; j++) begin
      w[8 * j +: 8] = payload_byte(seed, 4 * beat + j);
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic send_byte(input memreq_pkg::byte_t data, input logic last);
    @(negedge bus_clock);
    s_tvalid_i = 1'b1;
    s_tdata_i = data;
    s_tlast_i = last;
    while (!s_tready_o) @(negedge bus_clock);  // Transfers on the next rising edge
  endtask

  task automatic recv_byte(output memreq_pkg::byte_t data, output logic last);
    logic fired;
    fired = 1'b0;
    while (!fired) begin
      @(negedge bus_clock);
      tb_rng = lcg_step(tb_rng);
      m_tready_i = |tb_rng[31:30];
      fired = m_tvalid_o && m_tready_i;
    end
    data = m_tdata_o;
    last = m_tlast_o;
  endtask

  // Memory model, decides each handshake half a cycle before the edge
  always @(negedge bus_clock) begin
    if (bus_reset) begin
      for (int i = 0; i < 256; i++) mem[i] = fill_word(i);
      awready_i = 1'b0;
      wready_i = 1'b0;
      arready_i = 1'b0;
      bvalid_i = 1'b0;
      rvalid_i = 1'b0;
      r_active = 1'b0;
      b_fire = 1'b0;
      r_fire = 1'b0;
    end else begin
      if (b_fire) bvalid_i = 1'b0;
      if (r_fire) begin
        rvalid_i = 1'b0;
        if (rlast_i) r_active = 1'b0;
        r_beat = r_beat + 1;
      end
      mem_rng = lcg_step(mem_rng);
      awready_i = |mem_rng[31:30];
      wready_i = |mem_rng[29:28];
      arready_i = |mem_rng[27:26];
      if (r_active && !rvalid_i && |mem_rng[25:24]) begin
        rvalid_i = 1'b1;
        rdata_i = mem[ar_addr[7:0] + r_beat[7:0]];
        rresp_i = ar_addr[27] ? 2'd2 : 2'd0;
        rid_i = ar_id;
        rlast_i = (r_beat == int'(ar_len));
      end
      if (awvalid_o && awready_i) begin
        aw_addr = awaddr_o;
        aw_len = awlen_o;
        aw_id = awid_o;
        aw_total = aw_total + 1;
        wr_count = 0;
        wlast_at = -1;
      end
      if (wvalid_o && wready_i) begin
        wr_log[wr_count[7:0]] = wdata_o;
        if (!aw_addr[27]) mem[aw_addr[7:0] + wr_count[7:0]] = wdata_o;
        if (wlast_o) begin
          wlast_at = wr_count;
          bvalid_i = 1'b1;  // Response queued behind the last beat
          bresp_i = aw_addr[27] ? 2'd2 : 2'd0;
          bid_i = aw_id;
        end
        wr_count = wr_count + 1;
      end
      if (arvalid_o && arready_i) begin
        ar_addr = araddr_o;
        ar_len = arlen_o;
        ar_id = arid_o;
        ar_total = ar_total + 1;
        r_beat = 0;
        r_active = 1'b1;
      end
      b_fire = bvalid_i && bready_o;
      r_fire = rvalid_i && rready_o;
    end
  end

  always @(posedge bus_clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: requests not finished after %0d cycles", cycle_count);
      $display("sim failed");
      $fatal(1);
    end
  end

  initial begin : main
    memreq_pkg::byte_t cmd, seed, got, exp_byte;
    memreq_pkg::len_t len;
    memreq_pkg::addr_t addr;
    memreq_pkg::id_t id;
    memreq_pkg::data_t word;
    logic is_read, ok, got_last;
    int n_bytes, n_writes, n_reads;

    bus_reset = 1'b1;
    s_tvalid_i = 1'b0;
    s_tlast_i = 1'b0;
    s_tdata_i = '0;
    m_tready_i = 1'b0;
    n_writes = 0;
    n_reads = 0;
    for (int i = 0; i < 256; i++) exp_mem[i] = fill_word(i);
    repeat (RESET_CYCLES) @(posedge bus_clock);
    @(negedge bus_clock);
    bus_reset = 1'b0;

    for (int e = 0; e < NUM_REQ; e++) begin
      {cmd, len, addr, id, seed} = REQ_TABLE[e];
      is_read = cmd[7];
      ok = !addr[27];
      send_byte(cmd, 1'b0);
      send_byte(len, 1'b0);
      send_byte(addr[7:0], 1'b0);
      send_byte(addr[15:8], 1'b0);
      send_byte(addr[23:16], 1'b0);
      send_byte({id, addr[27:24]}, is_read);
      if (!is_read) begin
        for (int k = 0; k < 4 * (len + 1); k++) begin
          send_byte(payload_byte(seed, k), k == 4 * (len + 1) - 1);
        end
        if (ok) begin
          for (int b = 0; b <= int'(len); b++) exp_mem[addr[7:0] + b[7:0]] = pack_word(seed, b);
        end
      end
      @(negedge bus_clock);
      s_tvalid_i = 1'b0;
      s_tlast_i = 1'b0;

      n_bytes = is_read ? 2 + 4 * (len + 1) : 2;
      for (int k = 0; k < n_bytes; k++) begin
        recv_byte(got, got_last);
        if (k == 0) begin
          exp_byte = is_read ? (ok ? 8'h81 : 8'h82) : (ok ? 8'h02 : 8'h03);
        end else if (k == 1) begin
          exp_byte = {4'h0, id};
        end else begin
          word = exp_mem[addr[7:0] + 8'((k - 2) / 4)];
          exp_byte = word[8 * ((k - 2) % 4) +: 8];
        end
        if (k < 2 || ok) check_value("m_tdata_o", exp_byte, got);  // Error read data unchecked
        check_value("m_tlast_o", k == n_bytes - 1, got_last);
      end

      if (!is_read) begin
        n_writes = n_writes + 1;
        check_value("awvalid_o count", n_writes, aw_total);
        check_value("awaddr_o", addr, aw_addr);
        check_value("awlen_o", len, aw_len);
        check_value("awid_o", id, aw_id);
        check_value("wvalid_o count", len + 1, wr_count);
        check_value("wlast_o beat", len, wlast_at);
        for (int b = 0; b <= int'(len); b++) check_value("wdata_o", pack_word(seed, b), wr_log[b]);
      end else begin
        n_reads = n_reads + 1;
        check_value("arvalid_o count", n_reads, ar_total);
        check_value("araddr_o", addr, ar_addr);
        check_value("arlen_o", len, ar_len);
        check_value("arid_o", id, ar_id);
      end
    end

    $display("sim passed");
    $finish;
  end

endmodule

/* tb.f */
verilog/memreq_pkg.sv
verilog/cmd_parser.sv
verilog/word_packer.sv
verilog/word_fifo.sv
verilog/write_port.sv
verilog/read_port.sv
verilog/resp_sender.sv
verilog/memreq_top.sv
bench/memreq_props.sv
bench/tb_memreq.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memreq testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_memreq -f tb.f -Mdir obj_dir -o sim_memreq; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_memreq 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
echo "Pass message not found"
exit 1
